// ==== source/batch_defines.svh ====
`ifndef BATCH_DEFINES_SVH
`define BATCH_DEFINES_SVH

// Modulator bits per word, one filter channel per bit
`define NUM_CH 3

// Samples per batch, power of two
`define BATCH_DEPTH 32

// Real and imaginary part width
`define DATA_W 24

// Fractional bits of the fixed-point coefficients
`define COEF_FRAC 16

// Output sample width
`define OUT_W 24

// Input sample to output sample, in clocks.
// Backward pass of a batch needs the whole following batch first
`define LATENCY (4 * `BATCH_DEPTH + 4)

`endif

// ==== source/filterPkg.sv ====
`default_nettype none

`include "batch_defines.svh"

package filterPkg;

    typedef struct packed {
        logic signed [`DATA_W-1:0] re;
        logic signed [`DATA_W-1:0] im;
    } cplx_t;

    // Wrapping complex add
    function automatic cplx_t cadd(input cplx_t a, input cplx_t b);
        cplx_t r;
        r.re = a.re + b.re;
        r.im = a.im + b.im;
        return r;
    endfunction

    // Complex multiply, arithmetic shift truncates toward minus infinity
    function automatic cplx_t cmul(input cplx_t a, input cplx_t b);
        logic signed [2*`DATA_W-1:0] rr;
        logic signed [2*`DATA_W-1:0] ii;
        cplx_t r;
        rr = a.re * b.re - a.im * b.im;
        ii = a.re * b.im + a.im * b.re;
        r.re = `DATA_W'(rr >>> `COEF_FRAC);
        r.im = `DATA_W'(ii >>> `COEF_FRAC);
        return r;
    endfunction

    // Sum of table entries over the set bits of one modulator word
    function automatic cplx_t bitLookup(input cplx_t tbl [`NUM_CH],
                                        input logic [`NUM_CH-1:0] bits);
        cplx_t acc;
        acc = '0;
        for (int b = 0; b < `NUM_CH; b++) begin
            if (bits[b]) begin
                acc = cadd(acc, tbl[b]);
            end
        end
        return acc;
    endfunction

    // Poles, Q8.16
    localparam cplx_t lambdaF [`NUM_CH] = '{
        '{re: 62259, im: 6554}, '{re: 60948, im: -9830}, '{re: 63570, im: 3277}};
    localparam cplx_t lambdaB [`NUM_CH] = '{
        '{re: 61604, im: -6554}, '{re: 62914, im: 8192}, '{re: 59638, im: -4915}};

    // Output weights
    localparam cplx_t wF [`NUM_CH] = '{
        '{re: 8192, im: -1638}, '{re: -4096, im: 2458}, '{re: 6554, im: 983}};
    localparam cplx_t wB [`NUM_CH] = '{
        '{re: 7373, im: 1311}, '{re: -3277, im: -2048}, '{re: 5734, im: -819}};

    // Per channel, contribution of each input bit
    localparam cplx_t ffTable [`NUM_CH][`NUM_CH] = '{
        '{'{re: 4096, im: -1024}, '{re: 2048, im: 512}, '{re: -1536, im: 768}},
        '{'{re: -2048, im: 1280}, '{re: 3072, im: -256}, '{re: 1024, im: 2048}},
        '{'{re: 1536, im: 640}, '{re: -2560, im: -768}, '{re: 3584, im: -1280}}};
    localparam cplx_t fbTable [`NUM_CH][`NUM_CH] = '{
        '{'{re: 3584, im: 896}, '{re: -1792, im: 448}, '{re: 1280, im: -640}},
        '{'{re: 2304, im: -1152}, '{re: 2816, im: 320}, '{re: -896, im: 1792}},
        '{'{re: -1408, im: -576}, '{re: 2176, im: 704}, '{re: 3328, im: 1152}}};

endpackage

`default_nettype wire

// ==== source/batchPkg.sv ====
`default_nettype none

`include "batch_defines.svh"

package batchPkg;

    // Bank currently being written
    typedef enum logic [1:0] {
        PH0 = 2'd0,
        PH1 = 2'd1,
        PH2 = 2'd2,
        PH3 = 2'd3
    } bankPhase_t;

    typedef logic [$clog2(`BATCH_DEPTH)-1:0] batchAddr_t;

endpackage

`default_nettype wire

// ==== source/batchSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "batch_defines.svh"

module batchSequencer
    import batchPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    output batchAddr_t wrAddr,
    output batchAddr_t rdAddrRev,
    output bankPhase_t phase,
    output logic       batchStart,
    output logic       outValid
);

    logic [$clog2(`LATENCY)-1:0] latCnt;

    // Address counters and bank rotation
    always_ff @(posedge clk) begin
        if (!rst) begin
            wrAddr     <= '0;
            rdAddrRev  <= batchAddr_t'(`BATCH_DEPTH - 1);
            phase      <= PH0;
            batchStart <= 1'b1;
        end else begin
            wrAddr     <= wrAddr + 1'b1;
            rdAddrRev  <= rdAddrRev - 1'b1;
            batchStart <= (wrAddr == batchAddr_t'(`BATCH_DEPTH - 1));
            if (wrAddr == batchAddr_t'(`BATCH_DEPTH - 1)) begin
                phase <= bankPhase_t'(phase + 2'd1);
            end
        end
    end

    // Pipeline fill, counted from the first sample after reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            latCnt   <= '0;
            outValid <= 1'b0;
        end else if (!outValid) begin
            latCnt <= latCnt + 1'b1;
            if (latCnt == ($clog2(`LATENCY))'(`LATENCY - 1)) begin
                outValid <= 1'b1;
            end
        end
    end

    // Reversed address tracks the forward one across wraps
    assert property (@(posedge clk) disable iff (!rst)
        rdAddrRev == batchAddr_t'(`BATCH_DEPTH - 1) - wrAddr);

endmodule

`default_nettype wire

// ==== source/sampleBank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "batch_defines.svh"

module sampleBank
    import batchPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [`NUM_CH-1:0] sampleIn,
    input  batchAddr_t         wrAddr,
    input  batchAddr_t         rdAddrRev,
    input  bankPhase_t         phase,
    output logic [`NUM_CH-1:0] fwdBits,
    output logic [`NUM_CH-1:0] bwdBits,
    output logic [`NUM_CH-1:0] lookBits
);

    logic [`NUM_CH-1:0] mem [4][`BATCH_DEPTH];
    logic [3:0]         wrEn;
    logic [3:0]         bankFull;
    logic [1:0]         lookSel;
    logic [1:0]         oldSel;

    assign wrEn = 4'b0001 << phase;

    // Batch just finished feeds the lookahead
    assign lookSel = 2'(phase - 2'd1);
    // Oldest batch, three phases back, feeds both main recursions
    assign oldSel = 2'(phase + 2'd1);

    always_ff @(posedge clk) begin
        mem[phase][wrAddr] <= sampleIn;
    end

    // Banks not yet written since reset read as zero
    always_ff @(posedge clk) begin
        if (!rst) begin
            bankFull <= '0;
        end else begin
            bankFull <= bankFull | wrEn;
        end
    end

    always_ff @(posedge clk) begin
        fwdBits  <= bankFull[oldSel] ? mem[oldSel][wrAddr] : '0;
        bwdBits  <= bankFull[oldSel] ? mem[oldSel][rdAddrRev] : '0;
        lookBits <= bankFull[lookSel] ? mem[lookSel][rdAddrRev] : '0;
    end

    // Written bank only moves on at a batch boundary
    assert property (@(posedge clk) disable iff (!rst)
        (wrAddr != '0) |-> (phase == $past(phase)));

endmodule

`default_nettype wire

// ==== source/recursionUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "batch_defines.svh"

module recursionUnit
    import filterPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  cplx_t lambda,
    input  cplx_t inVal,
    input  logic  load,
    input  cplx_t loadVal,
    output cplx_t state
);

    cplx_t decayed;

    assign decayed = cmul(lambda, state);

    // s <= lambda * s + x, or restart from loadVal + x
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= '0;
        end else if (load) begin
            state <= cadd(loadVal, inVal);
        end else begin
            state <= cadd(decayed, inVal);
        end
    end

endmodule

`default_nettype wire

// ==== source/channelCompute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "batch_defines.svh"

module channelCompute
    import filterPkg::*;
    import batchPkg::*;
#(
    parameter int CH = 0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`NUM_CH-1:0]        fwdBits,
    input  logic [`NUM_CH-1:0]        bwdBits,
    input  logic [`NUM_CH-1:0]        lookBits,
    input  logic                      batchStart,
    input  logic                      phaseOdd,
    input  batchAddr_t                wrAddr,
    input  batchAddr_t                rdAddrRev,
    output logic signed [`DATA_W-1:0] partOut
);

    logic       startQ;
    batchAddr_t addrQ1;
    batchAddr_t addrQ2;
    batchAddr_t revQ1;
    batchAddr_t revQ2;
    logic       oddQ1;
    logic       oddQ2;

    cplx_t lookIn;
    cplx_t fwdIn;
    cplx_t bwdIn;
    cplx_t lookState;
    cplx_t fwdState;
    cplx_t bwdState;
    cplx_t bwdStart;
    cplx_t fwdWeighted;
    cplx_t bwdWeighted;

    // Ping-pong part results, one pair per direction
    logic signed [`DATA_W-1:0] partF [2][`BATCH_DEPTH];
    logic signed [`DATA_W-1:0] partB [2][`BATCH_DEPTH];

    // Bank reads land one cycle late, recursion state one more
    always_ff @(posedge clk) begin
        if (!rst) begin
            startQ <= 1'b0;
            addrQ1 <= '0;
            addrQ2 <= '0;
            revQ1  <= '0;
            revQ2  <= '0;
            oddQ1  <= 1'b0;
            oddQ2  <= 1'b0;
        end else begin
            startQ <= batchStart;
            addrQ1 <= wrAddr;
            addrQ2 <= addrQ1;
            revQ1  <= rdAddrRev;
            revQ2  <= revQ1;
            oddQ1  <= phaseOdd;
            oddQ2  <= oddQ1;
        end
    end

    assign lookIn = bitLookup(fbTable[CH], lookBits);
    assign fwdIn  = bitLookup(ffTable[CH], fwdBits);
    assign bwdIn  = bitLookup(fbTable[CH], bwdBits);

    // Lookahead ends on B[0] of the following batch, which acts as B[last+1]
    assign bwdStart = cmul(lambdaB[CH], lookState);

    recursionUnit lookRec_i (
        .clk    (clk),
        .rst    (rst),
        .lambda (lambdaB[CH]),
        .inVal  (lookIn),
        .load   (startQ),
        .loadVal('0),
        .state  (lookState)
    );

    // Forward runs across batch boundaries without restart
    recursionUnit fwdRec_i (
        .clk    (clk),
        .rst    (rst),
        .lambda (lambdaF[CH]),
        .inVal  (fwdIn),
        .load   (1'b0),
        .loadVal('0),
        .state  (fwdState)
    );

    recursionUnit bwdRec_i (
        .clk    (clk),
        .rst    (rst),
        .lambda (lambdaB[CH]),
        .inVal  (bwdIn),
        .load   (startQ),
        .loadVal(bwdStart),
        .state  (bwdState)
    );

    assign fwdWeighted = cmul(wF[CH], fwdState);
    assign bwdWeighted = cmul(wB[CH], bwdState);

    // Backward results stored at their sample index, so both read in order
    always_ff @(posedge clk) begin
        partF[oddQ2][addrQ2] <= fwdWeighted.re;
        partB[oddQ2][revQ2]  <= bwdWeighted.re;
    end

    // Other half holds the batch finished during the previous phase
    always_ff @(posedge clk) begin
        partOut <= partF[~oddQ2][addrQ2] + partB[~oddQ2][addrQ2];
    end

endmodule

`default_nettype wire

// ==== source/batchFilterTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "batch_defines.svh"

module batchFilterTop
    import batchPkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`NUM_CH-1:0]       sampleIn,
    output logic signed [`OUT_W-1:0] out,
    output logic                     outValid
);

    batchAddr_t         wrAddr;
    batchAddr_t         rdAddrRev;
    bankPhase_t         phase;
    logic               batchStart;
    logic [`NUM_CH-1:0] fwdBits;
    logic [`NUM_CH-1:0] bwdBits;
    logic [`NUM_CH-1:0] lookBits;

    logic signed [`DATA_W-1:0] partRes  [`NUM_CH];
    logic signed [`DATA_W-1:0] chainSum [`NUM_CH];

    batchSequencer seq_i (
        .clk       (clk),
        .rst       (rst),
        .wrAddr    (wrAddr),
        .rdAddrRev (rdAddrRev),
        .phase     (phase),
        .batchStart(batchStart),
        .outValid  (outValid)
    );

    sampleBank bank_i (
        .clk      (clk),
        .rst      (rst),
        .sampleIn (sampleIn),
        .wrAddr   (wrAddr),
        .rdAddrRev(rdAddrRev),
        .phase    (phase),
        .fwdBits  (fwdBits),
        .bwdBits  (bwdBits),
        .lookBits (lookBits)
    );

    for (genvar i = 0; i < `NUM_CH; i++) begin : gCh
        channelCompute #(.CH(i)) ch_i (
            .clk       (clk),
            .rst       (rst),
            .fwdBits   (fwdBits),
            .bwdBits   (bwdBits),
            .lookBits  (lookBits),
            .batchStart(batchStart),
            .phaseOdd  (phase[0]),
            .wrAddr    (wrAddr),
            .rdAddrRev (rdAddrRev),
            .partOut   (partRes[i])
        );

        // Adder chain across channels
        if (i == 0) begin : gFirst
            assign chainSum[i] = partRes[i];
        end else begin : gNext
            assign chainSum[i] = chainSum[i-1] + partRes[i];
        end
    end

    always_ff @(posedge clk) begin
        out <= `OUT_W'(chainSum[`NUM_CH-1]);
    end

endmodule

`default_nettype wire

// ==== tb/batchFilterTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "batch_defines.svh"

module batchFilterTb
    import filterPkg::*;
();

    localparam int BD = `BATCH_DEPTH;
    localparam int SEG1_LEN = 24 * BD;
    localparam int SEG2_LEN = 8 * BD;
    // Both segments, both resets, pipeline fill and some slack
    localparam int TIMEOUT_CYCLES = SEG1_LEN + SEG2_LEN + 6 + `LATENCY + 50;
    localparam logic [31:0] SEED = 32'h8236_5a75;

    localparam int FILL_RANDOM = 0;
    localparam int FILL_ZERO = 1;
    localparam int FILL_ONES = 2;

    logic                     clk;
    logic                     rst;
    logic [`NUM_CH-1:0]       sampleIn;
    logic signed [`OUT_W-1:0] out;
    logic                     outValid;

    logic [`NUM_CH-1:0]       stream [SEG1_LEN];
    logic signed [`OUT_W-1:0] expOut [SEG1_LEN];
    int errors;
    int checks;
    int cycles;
    int seedDummy;

    batchFilterTop dut_i (
        .clk     (clk),
        .rst     (rst),
        .sampleIn(sampleIn),
        .out     (out),
        .outValid(outValid)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic cplx_t wrapAdd(input cplx_t a, input cplx_t b);
        cplx_t r;
        r.re = a.re + b.re;
        r.im = a.im + b.im;
        return r;
    endfunction

    // s = lambda * s + x
    function automatic cplx_t stepRec(input cplx_t lambda, input cplx_t s, input cplx_t x);
        return wrapAdd(cmul(lambda, s), x);
    endfunction

    task automatic fillBatches(input int first, input int count, input int kind);
        for (int n = first * BD; n < (first + count) * BD; n++) begin
            if (kind == FILL_RANDOM) begin
                stream[n] = `NUM_CH'($urandom());
            end else if (kind == FILL_ZERO) begin
                stream[n] = '0;
            end else begin
                stream[n] = '1;
            end
        end
    endtask

    // Reference outputs from zero state; a batch needs the next one for its lookahead
    task automatic buildModel(input int len);
        cplx_t f;
        cplx_t l;
        cplx_t b;
        cplx_t w;
        int base;
        for (int n = 0; n < len; n++) begin
            expOut[n] = '0;
        end
        for (int c = 0; c < `NUM_CH; c++) begin
            f = '0;
            for (int n = 0; n < len; n++) begin
                f = stepRec(lambdaF[c], f, bitLookup(ffTable[c], stream[n]));
                w = cmul(wF[c], f);
                expOut[n] = expOut[n] + w.re;
            end
            for (int k = 0; (k + 2) * BD <= len; k++) begin
                base = k * BD;
                l = '0;
                for (int i = BD - 1; i >= 0; i--) begin
                    l = stepRec(lambdaB[c], l, bitLookup(fbTable[c], stream[base + BD + i]));
                end
                // Lookahead result stands in for B just past the batch end
                b = l;
                for (int i = BD - 1; i >= 0; i--) begin
                    b = stepRec(lambdaB[c], b, bitLookup(fbTable[c], stream[base + i]));
                    w = cmul(wB[c], b);
                    expOut[base + i] = expOut[base + i] + w.re;
                end
            end
        end
    endtask

    task automatic checkOutput(input int m);
        logic expValid;
        int n;
        expValid = (m >= `LATENCY);
        n = m - `LATENCY;
        checks++;
        if (outValid !== expValid) begin
            errors++;
            $display("[ERROR] %0t outValid: expected %b, got %b", $time, expValid, outValid);
        end else if (expValid && out !== expOut[n]) begin
            errors++;
            $display("[ERROR] %0t out: expected %0d, got %0d (sample %0d)",
                     $time, expOut[n], out, n);
        end
    endtask

    // First edge also releases reset
    task automatic runSegment(input int len);
        for (int m = 0; m < len; m++) begin
            @(posedge clk);
            rst <= 1'b1;
            sampleIn <= stream[m];
            @(negedge clk);
            checkOutput(m);
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        checks++;
        if (outValid !== 1'b0) begin
            errors++;
            $display("[ERROR] %0t outValid: expected 0, got %b", $time, outValid);
        end
        @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        sampleIn = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        seedDummy = $urandom(SEED);

        // Random data, silence, full-scale input, then random again
        fillBatches(0, 12, FILL_RANDOM);
        fillBatches(12, 3, FILL_ZERO);
        fillBatches(15, 4, FILL_ONES);
        fillBatches(19, 5, FILL_RANDOM);
        buildModel(SEG1_LEN);
        repeat (2) @(posedge clk);
        runSegment(SEG1_LEN);

        // Reset in mid-stream, model restarts from zero state
        fillBatches(0, 8, FILL_RANDOM);
        buildModel(SEG2_LEN);
        applyReset();
        runSegment(SEG2_LEN);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/filterPkg.sv
source/batchPkg.sv
source/batchSequencer.sv
source/sampleBank.sv
source/recursionUnit.sv
source/channelCompute.sv
source/batchFilterTop.sv
tb/batchFilterTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module batchFilterTb -o batchFilterSim
./obj_dir/batchFilterSim | tee sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
